// File: access_decode.sv
/* decode stage of the data port, purely combinational
   classifies the address, builds ram byte enables and the load descriptor */
`include "ramio_consts.svh"

module access_decode
  import ramio_pkg::*;
(
  input  logic          enable,
  input  access_width_e write_type,
  input  load_kind_t    read_type,
  input  logic [31:0]   address,
  input  logic [31:0]   data_in,
  output mem_req_t      req,
  output rd_desc_t      rd_desc
);

  target_e    tgt;
  logic [1:0] offset;

  assign offset = address[1:0];

  // i/o only on an exact match, everything else is ram
  always_comb begin
    case (address)
      `RAMIO_ADDR_LED:      tgt = tgt_led;
      `RAMIO_ADDR_UART_OUT: tgt = tgt_uart_out;
      `RAMIO_ADDR_UART_IN:  tgt = tgt_uart_in;
      default:              tgt = tgt_ram;
    endcase
  end

  always_comb begin
    req           = '0;
    req.target    = tgt;
    req.word_addr = address[`RAMIO_RAM_AW+1:2];
    // replicate small stores so every lane carries the data, low byte included
    case (write_type)
      width_byte: req.wdata = {4{data_in[7:0]}};
      width_half: req.wdata = {2{data_in[15:0]}};
      default:    req.wdata = data_in;
    endcase
    if (enable && tgt == tgt_ram) begin
      case (write_type)
        width_byte: req.byte_en = 4'b0001 << offset;
        width_half: if (!offset[0]) req.byte_en = offset[1] ? 4'b1100 : 4'b0011; // odd -> none
        width_word: if (offset == 2'b00) req.byte_en = 4'b1111;  // misaligned word dropped
        default:    ;
      endcase
    end
    req.io_wr = enable && tgt != tgt_ram && write_type == width_byte;
    req.io_rd = enable && tgt == tgt_uart_in && read_type.width == width_byte;
  end

  always_comb begin
    rd_desc.valid  = enable && read_type.width != width_none;
    rd_desc.target = tgt;
    rd_desc.kind   = read_type;
    rd_desc.offset = offset;
  end

  // a port access is either an i/o store or an i/o load, never both
  always_comb begin
    a_io_excl: assert final (!(req.io_wr && req.io_rd))
      else $error("access_decode: i/o store and i/o load in one access");
  end

endmodule

// File: compile.f
+incdir+.
ramio_pkg.sv
uart_tx.sv
uart_rx.sv
access_decode.sv
word_ram.sv
io_regs.sv
load_align.sv
ramio.sv
ramio_tb.sv

// File: io_regs.sv
/* execute stage i/o, led register plus uart transmit and receive bytes
   read byte is registered alongside the ram read */
module io_regs
  import ramio_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  mem_req_t   req,
  output logic [3:0] led,
  output logic [7:0] io_rdata,
  output logic       uart_tx,
  input  logic       uart_rx
);

  logic [7:0] tx_byte;       // byte handed to the transmitter
  logic       go;            // held high until the frame is out
  logic       tx_busy;
  logic       tx_seen_busy;  // transmitter picked up the byte
  logic [7:0] rx_data;
  logic       rx_ready;
  logic [7:0] rx_hold;       // last received byte, cleared on read

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led          <= 4'b1111;  // all leds off
      tx_byte      <= '0;
      go           <= 1'b0;
      tx_seen_busy <= 1'b0;
      rx_hold      <= '0;
    end else begin
      if (req.io_wr && req.target == tgt_led) led <= req.wdata[3:0];
      if (go && tx_busy) tx_seen_busy <= 1'b1;
      // busy fell after being up, frame done so acknowledge
      if (go && tx_seen_busy && !tx_busy) begin
        go           <= 1'b0;
        tx_byte      <= '0;
        tx_seen_busy <= 1'b0;
      end
      // a write while go is still up is lost
      if (req.io_wr && req.target == tgt_uart_out && !go) begin
        tx_byte <= req.wdata[7:0];
        go      <= 1'b1;
      end
      if (req.io_rd) rx_hold <= '0;
      if (rx_ready) rx_hold <= rx_data;  // new byte wins, overrun not flagged
    end
  end

  always_ff @(posedge clk) begin
    case (req.target)
      tgt_uart_out: io_rdata <= tx_byte;
      tgt_uart_in:  io_rdata <= rx_hold;  // value before the clear-on-read
      default:      io_rdata <= '0;
    endcase
  end

  uart_tx tx_i (.clk(clk), .rst_n(rst_n), .data(tx_byte), .go(go), .tx(uart_tx), .busy(tx_busy));

  uart_rx rx_i (.clk(clk), .rst_n(rst_n), .rx(uart_rx), .data(rx_data), .ready(rx_ready));

  // go may only rise with the transmitter idle
  a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (!go && tx_busy) |=> !go)
    else $error("io_regs: go raised while the transmitter is busy");

endmodule

// File: load_align.sv
/* result stage, holds the load descriptor for one cycle
   then picks ram or i/o data and aligns and extends it */
module load_align
  import ramio_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  rd_desc_t    rd_desc,
  input  logic [31:0] ram_rdata,
  input  logic [7:0]  io_rdata,
  output logic [31:0] data_out,
  output logic        data_out_ready
);

  rd_desc_t desc_q;

  function automatic logic [31:0] ext8(input logic [7:0] b, input logic s);
    return s ? {{24{b[7]}}, b} : {24'b0, b};
  endfunction

  function automatic logic [31:0] ext16(input logic [15:0] h, input logic s);
    return s ? {{16{h[15]}}, h} : {16'b0, h};
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) desc_q <= '0;
    else desc_q <= rd_desc;
  end

  always_comb begin
    data_out = '0;
    case (desc_q.target)
      tgt_ram: begin
        case (desc_q.kind.width)
          width_byte: data_out = ext8(ram_rdata[{desc_q.offset, 3'b000} +: 8],
                                      desc_q.kind.sign_ext);
          width_half: if (!desc_q.offset[0]) begin  // odd offset reads zero
            data_out = ext16(desc_q.offset[1] ? ram_rdata[31:16] : ram_rdata[15:0],
                             desc_q.kind.sign_ext);
          end
          width_word: if (desc_q.offset == 2'b00) data_out = ram_rdata;
          default:    ;
        endcase
      end
      tgt_uart_out, tgt_uart_in: begin
        if (desc_q.kind.width == width_byte) data_out = ext8(io_rdata, desc_q.kind.sign_ext);
      end
      default: ;  // led is write only, reads zero
    endcase
  end

  assign data_out_ready = desc_q.valid;  // one pulse per load

endmodule

// File: ramio.sv
/* ram and i/o data port of the core
   decode, then ram and i/o registers, then load alignment */
module ramio
  import ramio_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          enable,
  input  access_width_e write_type,
  input  load_kind_t    read_type,
  input  logic [31:0]   address,
  input  logic [31:0]   data_in,
  output logic [31:0]   data_out,
  output logic          data_out_ready,
  output logic [3:0]    led,
  output logic          uart_tx,
  input  logic          uart_rx
);

  mem_req_t    req;
  rd_desc_t    rd_desc;
  logic [31:0] ram_rdata;
  logic [7:0]  io_rdata;

  access_decode decode_i (
    .enable     (enable),
    .write_type (write_type),
    .read_type  (read_type),
    .address    (address),
    .data_in    (data_in),
    .req        (req),
    .rd_desc    (rd_desc)
  );

  word_ram ram_i (.clk(clk), .rst_n(rst_n), .req(req), .rdata(ram_rdata));

  io_regs io_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .led      (led),
    .io_rdata (io_rdata),
    .uart_tx  (uart_tx),
    .uart_rx  (uart_rx)
  );

  load_align align_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_desc        (rd_desc),
    .ram_rdata      (ram_rdata),
    .io_rdata       (io_rdata),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

endmodule

// File: ramio_consts.svh
/* address map and sizing for the ram and i/o data port
   include wherever an i/o address, the ram depth or the uart bit period is needed */
`ifndef RAMIO_CONSTS_SVH
`define RAMIO_CONSTS_SVH

// i/o registers sit at the very top of the byte address space
`define RAMIO_ADDR_LED      32'hFFFF_FFFF
`define RAMIO_ADDR_UART_OUT 32'hFFFF_FFFE
`define RAMIO_ADDR_UART_IN  32'hFFFF_FFFD

// ram word index width, 256 words of 32 bits
`define RAMIO_RAM_AW 8

// clocks per uart bit, a frame is 10 bits long
`define RAMIO_CLKS_PER_BIT 8

`endif

// File: ramio_pkg.sv
/* types shared by the decode, execute and result stages of the data port
   modules pull them in with a wildcard import in their header */
`include "ramio_consts.svh"

package ramio_pkg;

  // store and load width, none means no access of that kind
  typedef enum logic [1:0] {
    width_none = 2'd0,
    width_byte = 2'd1,
    width_half = 2'd2,
    width_word = 2'd3
  } access_width_e;

  // load request, top bit flags sign extension
  typedef struct packed {
    logic          sign_ext;
    access_width_e width;
  } load_kind_t;

  // where an access lands
  typedef enum logic [1:0] {
    tgt_ram,
    tgt_led,
    tgt_uart_out,
    tgt_uart_in
  } target_e;

  // decoded request, decode -> execute
  typedef struct packed {
    target_e                  target;
    logic [`RAMIO_RAM_AW-1:0] word_addr;
    logic [3:0]               byte_en;    // ram lanes written
    logic [31:0]              wdata;      // already placed in lanes
    logic                     io_wr;      // byte store to an i/o register
    logic                     io_rd;      // byte load of uart in, clears it
  } mem_req_t;

  // load in flight, decode -> result pipeline register
  typedef struct packed {
    logic       valid;
    target_e    target;
    load_kind_t kind;
    logic [1:0] offset;     // byte address low bits
  } rd_desc_t;

endpackage

// File: ramio_tb.sv
/* self-checking testbench for the ram and i/o data port
   drives loads and stores, models the ram with a shadow byte array, loops uart back */
`include "ramio_consts.svh"

module ramio_tb
  import ramio_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NWORDS = 6;          // random words used by the ram tests
  localparam int CPB    = `RAMIO_CLKS_PER_BIT;

  logic          clk;
  logic          rst_n;
  logic          enable;
  access_width_e write_type;
  load_kind_t    read_type;
  logic [31:0]   address;
  logic [31:0]   data_in;
  logic [31:0]   data_out;
  logic          data_out_ready;
  logic [3:0]    led;
  wire           uart_line;           // tx looped straight back to rx

  logic [7:0]  shadow [1024];         // byte image of the ram indexed by address[9:0]
  logic [31:0] exp_q [$];             // expected data_out in issue order
  int          due_q [$];             // cycle in which each result must show
  logic [31:0] lfsr_state = 32'h3487;
  logic [7:0]  widx [NWORDS];
  int          cyc = 0;
  int          err_count = 0;
  int          test_errs0;
  int          tests_ok = 0;
  int          tests_bad = 0;

  ramio ramio_i (
    .clk(clk), .rst_n(rst_n), .enable(enable), .write_type(write_type),
    .read_type(read_type), .address(address), .data_in(data_in), .data_out(data_out),
    .data_out_ready(data_out_ready), .led(led), .uart_tx(uart_line), .uart_rx(uart_line)
  );

  always #20 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] extend(input logic [31:0] v, input int nbits, input logic s);
    logic [31:0] m;
    m = (nbits == 32) ? 32'hFFFF_FFFF : ((32'd1 << nbits) - 1);
    v = v & m;
    if (s && v[nbits-1]) v = v | ~m;  // copy the top bit upward
    return v;
  endfunction

  // byte loads at any offset, halves on even offsets and words on offset 0 only
  function automatic logic [31:0] expected_load(input load_kind_t kind, input logic [31:0] addr,
                                                input logic [31:0] word);
    logic [31:0] sh;
    sh = word >> (8 * addr[1:0]);
    case (kind.width)
      width_byte: return extend(sh, 8, kind.sign_ext);
      width_half: return addr[0] ? 32'h0 : extend(sh, 16, kind.sign_ext);
      width_word: return (addr[1:0] == 2'b00) ? word : 32'h0;
      default:    return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    logic [9:0] b;
    b = {addr[9:2], 2'b00};
    return {shadow[b + 3], shadow[b + 2], shadow[b + 1], shadow[b]};
  endfunction

  function automatic logic is_io(input logic [31:0] addr);
    return addr == `RAMIO_ADDR_LED || addr == `RAMIO_ADDR_UART_OUT ||
           addr == `RAMIO_ADDR_UART_IN;
  endfunction

  // ram byte address with bit 31 low so it never hits the i/o block
  function automatic logic [31:0] ram_addr(input logic [7:0] w, input logic [1:0] off);
    logic [20:0] hi;
    hi = 21'(take_bits(21));
    return {1'b0, hi, w, off};
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_led(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("[ERROR] led got 0x%01h expected 0x%01h", got, exp);
      err_count++;
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #5;
    enable     = 1'b0;
    write_type = width_none;
    read_type  = '0;
  endtask

  task automatic do_store(input access_width_e w, input logic [31:0] addr,
                          input logic [31:0] d);
    logic [9:0] b;
    @(posedge clk);
    #5;
    enable     = 1'b1;
    write_type = w;
    read_type  = '0;
    address    = addr;
    data_in    = d;
    b = addr[9:0];
    if (!is_io(addr)) begin  // shadow follows the store rules
      case (w)
        width_byte: shadow[b] = d[7:0];
        width_half: if (!b[0]) {shadow[b + 1], shadow[b]} = d[15:0];
        width_word: if (b[1:0] == 2'b00) shadow_fill_word(b, d);
        default:    ;
      endcase
    end
  endtask

  task automatic shadow_fill_word(input logic [9:0] b, input logic [31:0] d);
    {shadow[b + 3], shadow[b + 2], shadow[b + 1], shadow[b]} = d;
  endtask

  task automatic do_load(input load_kind_t k, input logic [31:0] addr, input logic [31:0] exp);
    @(posedge clk);
    #5;
    enable     = 1'b1;
    write_type = width_none;
    read_type  = k;
    address    = addr;
    exp_q.push_back(exp);
    due_q.push_back(cyc + 1);  // result shows in the cycle after the sampling edge
  endtask

  task automatic ram_load(input load_kind_t k, input logic [31:0] addr);
    do_load(k, addr, expected_load(k, addr, shadow_word(addr)));
  endtask

  task automatic drain_loads();
    int n;
    drive_idle();
    n = 0;
    while (exp_q.size() != 0 && n < 8) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d load results never arrived", exp_q.size());
      err_count++;
      exp_q.delete();
      due_q.delete();
    end
    repeat (2) @(posedge clk);  // stray pulses get caught by the checker
  endtask

  task automatic end_test(input string name);
    if (err_count == test_errs0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: fail, %0d errors", name, err_count - test_errs0);
    end
    test_errs0 = err_count;
  endtask

  // checks each result pulse against the queue at mid-cycle where outputs are settled
  always @(negedge clk) begin : result_check
    logic [31:0] exp_v;
    int          due;
    if (rst_n && data_out_ready) begin
      if (exp_q.size() == 0) begin
        $display("data_out_ready pulsed with no load pending at cycle %0d", cyc);
        err_count++;
      end else begin
        exp_v = exp_q.pop_front();
        due   = due_q.pop_front();
        if (cyc != due) begin
          $display("load result arrived in cycle %0d instead of %0d", cyc, due);
          err_count++;
        end
        check_word("data_out", data_out, exp_v);
      end
    end
  end

  initial begin : stimulus
    load_kind_t  k;
    logic [7:0]  tx_b;
    logic [31:0] d;
    int          n;
    clk        = 1'b0;
    rst_n      = 1'b0;
    enable     = 1'b0;
    write_type = width_none;
    read_type  = '0;
    address    = '0;
    data_in    = '0;
    test_errs0 = 0;
    repeat (2) @(posedge clk);
    #5 rst_n = 1'b1;

    // reset values
    if (data_out_ready !== 1'b0) begin
      $display("data_out_ready not low after reset");
      err_count++;
    end
    check_led(led, 4'b1111);
    k = {1'b0, width_word};
    do_load(k, `RAMIO_ADDR_LED, 32'h0);
    drain_loads();
    end_test("reset values");

    // aligned word stores then back to back loads of every width, offset and sign
    for (int i = 0; i < NWORDS; i++) begin
      widx[i] = 8'(take_bits(8));
      do_store(width_word, ram_addr(widx[i], 2'b00), take_bits(32));
    end
    for (int i = 0; i < NWORDS; i++)
      for (int w = 1; w < 4; w++)
        for (int off = 0; off < 4; off++)
          for (int s = 0; s < 2; s++) begin
            k = {s[0], access_width_e'(w)};
            ram_load(k, ram_addr(widx[i], off[1:0]));
          end
    drain_loads();
    end_test("aligned stores and loads");

    // byte and half stores merge into their lanes only
    k = {1'b0, width_word};
    for (int i = 0; i < 4; i++) begin
      do_store(width_byte, ram_addr(widx[i], 2'(take_bits(2))), take_bits(32));
      do_store(width_half, ram_addr(widx[i], {1'(take_bits(1)), 1'b0}), take_bits(32));
      ram_load(k, ram_addr(widx[i], 2'b00));
    end
    drain_loads();
    end_test("lane merge");

    // misaligned stores are dropped and misaligned loads read zero
    for (int i = 0; i < 3; i++) begin
      do_store(width_half, ram_addr(widx[i], 2'b01), take_bits(32));
      do_store(width_half, ram_addr(widx[i], 2'b11), take_bits(32));
      for (int off = 1; off < 4; off++) begin
        do_store(width_word, ram_addr(widx[i], off[1:0]), take_bits(32));
      end
      ram_load({1'b0, width_word}, ram_addr(widx[i], 2'b00));
      ram_load({1'b1, width_half}, ram_addr(widx[i], 2'b11));
      ram_load({1'b0, width_word}, ram_addr(widx[i], 2'b10));
    end
    drain_loads();
    end_test("misaligned access");

    // led register takes byte stores only
    d = take_bits(8) & 32'hFE;  // bit 0 low keeps led away from its reset value
    do_store(width_byte, `RAMIO_ADDR_LED, d);
    drive_idle();
    check_led(led, d[3:0]);
    do_store(width_half, `RAMIO_ADDR_LED, d ^ 32'h0F);
    drive_idle();
    check_led(led, d[3:0]);  // half store ignored
    end_test("led register");

    // uart loopback with the first frame read signed and the second unsigned
    for (int f = 0; f < 2; f++) begin
      tx_b = 8'(take_bits(8)) | 8'h80;  // top bit set so the extension shows
      do_store(width_byte, `RAMIO_ADDR_UART_OUT, {24'h0, tx_b});
      drive_idle();
      n = 0;
      while (uart_line !== 1'b0 && n < 40) begin
        @(posedge clk);
        n++;
      end
      if (uart_line !== 1'b0) begin
        $display("timeout: uart start bit never appeared");
        err_count++;
      end
      repeat (10 * CPB + 8) @(posedge clk);  // whole frame plus receiver lag
      n = 0;
      while (uart_line !== 1'b1 && n < 4 * CPB) begin
        @(posedge clk);
        n++;
      end
      if (uart_line !== 1'b1) begin
        $display("timeout: uart line did not return to idle");
        err_count++;
      end
      k = {(f == 0), width_byte};
      do_load(k, `RAMIO_ADDR_UART_IN, extend({24'h0, tx_b}, 8, f == 0));
      do_load(k, `RAMIO_ADDR_UART_IN, 32'h0);  // cleared by the first read
      drain_loads();
    end
    end_test("uart loopback");

    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_count);
    if (tests_bad == 0 && err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: uart_rx.sv
/* 8n1 serial receiver, samples mid-bit after a two-flop synchroniser
   ready pulses one cycle at mid stop bit when the byte is good */
`include "ramio_consts.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] data,
  output logic       ready
);

  localparam int unsigned CPB = `RAMIO_CLKS_PER_BIT;
  localparam int unsigned BW  = $clog2(CPB);
  localparam logic [BW-1:0] BAUD_LAST = BW'(CPB - 1);
  localparam logic [BW-1:0] BAUD_HALF = BW'(CPB / 2 - 1);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

  rx_state_e     state;
  logic [1:0]    sync;
  logic          rx_s;      // synchronised line
  logic [BW-1:0] baud_cnt;
  logic [2:0]    bit_cnt;
  logic          sample;    // mid-bit of a data bit

  assign rx_s   = sync[1];
  assign sample = state == rx_data && baud_cnt == BAUD_LAST;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync     <= 2'b11;
      state    <= rx_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      ready    <= 1'b0;
    end else begin
      sync  <= {sync[0], rx};
      ready <= 1'b0;
      case (state)
        rx_idle: begin
          baud_cnt <= '0;
          if (!rx_s) state <= rx_start;  // falling edge, maybe a start bit
        end
        rx_start: begin
          if (baud_cnt == BAUD_HALF) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s ? rx_idle : rx_data;  // glitch if high again
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (sample) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= rx_stop;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin  // rx_stop
          if (baud_cnt == BAUD_LAST) begin
            state <= rx_idle;
            ready <= rx_s;  // framing error drops the byte
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample) data <= {rx_s, data[7:1]};  // lsb arrives first
  end

endmodule

// File: uart_tx.sv
/* 8n1 serial transmitter, starts a frame when go is seen high
   go must drop again before the next frame, busy covers start to end of stop */
`include "ramio_consts.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       tx,
  output logic       busy
);

  localparam int unsigned CPB = `RAMIO_CLKS_PER_BIT;
  localparam int unsigned BW  = $clog2(CPB);
  localparam logic [BW-1:0] BAUD_LAST = BW'(CPB - 1);

  typedef enum logic {tx_idle, tx_send} tx_state_e;

  tx_state_e     state;
  logic [BW-1:0] baud_cnt;
  logic [3:0]    bit_cnt;   // bit periods finished, start bit is 0
  logic [8:0]    shreg;     // data then stop
  logic          armed;     // go went low since the last frame
  logic          start;
  logic          bit_tick;

  assign start    = state == tx_idle && go && armed;
  assign bit_tick = state == tx_send && baud_cnt == BAUD_LAST;
  assign busy     = state == tx_send;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= tx_idle;
      tx       <= 1'b1;  // line idles high
      baud_cnt <= '0;
      bit_cnt  <= '0;
      armed    <= 1'b1;
    end else begin
      if (!go) armed <= 1'b1;
      if (start) begin
        state    <= tx_send;
        armed    <= 1'b0;
        tx       <= 1'b0;  // start bit
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end else if (bit_tick) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          state <= tx_idle;
          tx    <= 1'b1;
        end else begin
          tx      <= shreg[0];  // lsb first, then stop
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (state == tx_send) begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) shreg <= {1'b1, data};
    else if (bit_tick) shreg <= {1'b1, shreg[8:1]};
  end

endmodule

// File: word_ram.sv
/* execute stage ram, 32-bit words written per byte lane
   read word is registered, valid the cycle after the request */
`include "ramio_consts.svh"

module word_ram
  import ramio_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  mem_req_t    req,
  output logic [31:0] rdata
);

  localparam int unsigned DEPTH = 1 << `RAMIO_RAM_AW;

  logic [31:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (req.byte_en[i]) begin
        mem[req.word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
      end
    end
    // old word on a same-edge write, next access sees the new one
    if (req.target == tgt_ram) begin
      rdata <= mem[req.word_addr];
    end
  end

  // i/o accesses alias ram words, they must never write them
  a_ram_lanes: assert property (@(posedge clk) disable iff (!rst_n)
    req.target != tgt_ram |-> req.byte_en == 4'b0000)
    else $error("word_ram: byte enables set for an i/o target");

endmodule
